// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dualIssueCpuTb
FILELIST ?= dualIssueCpu.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dualIssueCpu.f ====
source/cpuPkg.sv
source/alu.sv
source/fetchStage.sv
source/decodeStage.sv
source/registerFile.sv
source/executeStage.sv
source/dualIssueCpu.sv
sim/dualIssueCpuTb.sv

// ==== sim/dualIssueCpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dualIssueCpuTb;

    localparam int addrWidth = 11;
    localparam int runLimit = 2000;

    logic clk;
    logic rst;
    logic enable;
    logic [addrWidth-1:0] pc;
    logic imemWrEn;
    logic [addrWidth-1:0] imemWrAddr;
    cpuPkg::wordT imemWrData;
    logic wbWrEn1;
    logic wbWrEn2;
    cpuPkg::regAddrT wbReg1;
    cpuPkg::regAddrT wbReg2;
    cpuPkg::wordT wbData1;
    cpuPkg::wordT wbData2;

    // program words and expected writebacks from the vector file
    logic [addrWidth-1:0] progAddr [$];
    cpuPkg::wordT progData [$];
    cpuPkg::regAddrT expReg [$];
    cpuPkg::wordT expData [$];

    int wbIndex = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    logic [31:0] lfsr = 32'he46c;

    dualIssueCpu #(
        .imemAddrWidth (addrWidth)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? 32'h80200003 : 32'h0);
    endfunction

    // enable drops only when both of two fresh bits are set
    function automatic logic nextEnable();
        logic bitA;
        logic bitB;
        lfsr = lfsrStep(lfsr);
        bitA = lfsr[0];
        lfsr = lfsrStep(lfsr);
        bitB = lfsr[0];
        return !(bitA && bitB);
    endfunction

    task automatic readVectors();
        int fd;
        int n;
        string line;
        logic [7:0] tag;
        logic [31:0] fieldA;
        logic [31:0] fieldB;
        fd = $fopen("sim/programVectors.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/programVectors.txt");
            otherErrors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h", tag, fieldA, fieldB);
                if (n == 3 && tag == "P") begin
                    progAddr.push_back(fieldA[addrWidth-1:0]);
                    progData.push_back(fieldB);
                end else if (n == 3 && tag == "W") begin
                    expReg.push_back(fieldA[4:0]);
                    expData.push_back(fieldB);
                end
            end
        end
        $fclose(fd);
    endtask

    // frozen or resetting pipeline shows pc 0 and no writes
    task automatic checkIdle();
        assert (pc == '0 && !wbWrEn1 && !wbWrEn2) else begin
            $display("Error at %0t ns: idle pipeline shows pc %0d, wbWrEn %b%b",
                $time, pc, wbWrEn1, wbWrEn2);
            valueErrors++;
        end
    endtask

    task automatic checkWriteback(
        input int              lane,
        input cpuPkg::regAddrT reg_,
        input cpuPkg::wordT    data
    );
        assert (reg_ != '0) else begin
            $display("Error at %0t ns: lane %0d writes register 0", $time, lane);
            valueErrors++;
        end
        assert (wbIndex < expReg.size()) else begin
            $display("unexpected extra writeback on lane %0d at %0t ns", lane, $time);
            otherErrors++;
        end
        if (wbIndex < expReg.size()) begin
            assert (reg_ == expReg[wbIndex] && data == expData[wbIndex]) else begin
                $display("Error at %0t ns: lane %0d wrote r%0d = %h, expected r%0d = %h",
                    $time, lane, reg_, data, expReg[wbIndex], expData[wbIndex]);
                valueErrors++;
            end
            wbIndex++;
        end
    endtask

    // lane 1 holds the older writeback and is checked first
    always @(posedge clk) begin
        if (wbWrEn1) begin
            checkWriteback(1, wbReg1, wbData1);
        end
        if (wbWrEn2) begin
            checkWriteback(2, wbReg2, wbData2);
        end
    end

    initial begin
        logic [addrWidth-1:0] lastPc;
        int cycles;
        rst = 1'b1;
        enable = 1'b0;
        imemWrEn = 1'b0;
        imemWrAddr = '0;
        imemWrData = '0;
        readVectors();
        assert (progAddr.size() > 0 && expReg.size() > 0) else begin
            $display("vector file holds no program words or no expected writebacks");
            otherErrors++;
        end

        repeat (8) begin
            @(negedge clk);
            checkIdle();
        end
        rst = 1'b0;

        // load the program while enable is low
        for (int i = 0; i < progAddr.size(); i++) begin
            imemWrEn = 1'b1;
            imemWrAddr = progAddr[i];
            imemWrData = progData[i];
            @(negedge clk);
            checkIdle();
        end
        imemWrEn = 1'b0;

        enable = 1'b1;
        cycles = 0;
        while (wbIndex < expReg.size() && cycles < runLimit) begin
            lastPc = pc;
            @(negedge clk);
            assert (pc == (enable ? lastPc + 11'd2 : lastPc)) else begin
                $display("Error at %0t ns: pc %0d after %0d with enable %b",
                    $time, pc, lastPc, enable);
                valueErrors++;
            end
            enable = nextEnable();
            cycles++;
        end
        if (wbIndex < expReg.size()) begin
            $display("timeout, only %0d of %0d writebacks arrived", wbIndex, expReg.size());
            otherErrors++;
        end

        // let the padding drain so any surplus writeback shows up
        enable = 1'b1;
        repeat (6) @(negedge clk);

        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/programVectors.txt ====
# P <imem address> <instruction word>, hex
# W <register index> <expected writeback value>, hex, in program order
P 000 20010005
P 001 2002fffd
P 002 00221820
P 003 00412022
P 004 0081282a
P 005 00223024
P 006 00a33825
P 007 0024402a
P 008 3049ff00
P 009 348a1234
P 00a 20200007
P 00b 200bffff
P 00c 200c0064
P 00d 200c00c8
P 00e 01806820
P 00f 00007020
P 010 01ab7822
P 011 0160802a
P 012 00000000
P 013 00000000
P 014 00000000
P 015 00000000
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 fffffff8
W 05 00000001
W 06 00000005
W 07 00000003
W 08 00000000
W 09 0000ff00
W 0a fffffffc
W 0b ffffffff
W 0c 00000064
W 0c 000000c8
W 0d 000000c8
W 0e 00000000
W 0f 000000c9
W 10 00000001

// ==== source/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire cpuPkg::wordT  opA,
    input  wire cpuPkg::wordT  opB,
    input  wire cpuPkg::aluOpT aluOp,
    output cpuPkg::wordT       result
);

    always_comb begin
        case (aluOp)
            // add and sub simply wrap, no overflow detection
            cpuPkg::aluAdd: result = opA + opB;
            cpuPkg::aluSub: result = opA - opB;
            cpuPkg::aluAnd: result = opA & opB;
            cpuPkg::aluOr:  result = opA | opB;
            // signed compare, result is 0 or 1
            cpuPkg::aluSlt: result = {31'b0, $signed(opA) < $signed(opB)};
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // data word and instruction word share one width
    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // opcode field, instr[31:26]
    localparam opcodeT opRType = 6'h00;
    localparam opcodeT opAddi = 6'h08;
    localparam opcodeT opAndi = 6'h0c;
    localparam opcodeT opOri = 6'h0d;

    // function field of r-type, instr[5:0]
    localparam functT fnAdd = 6'h20;
    localparam functT fnSub = 6'h22;
    localparam functT fnAnd = 6'h24;
    localparam functT fnOr = 6'h25;
    localparam functT fnSlt = 6'h2a;

endpackage

`default_nettype wire

// ==== source/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           enable,
    input  wire cpuPkg::wordT   fdInstr1,
    input  wire cpuPkg::wordT   fdInstr2,
    input  wire logic           fdValid,
    // register file read side
    output cpuPkg::regAddrT     rs1,
    output cpuPkg::regAddrT     rt1,
    output cpuPkg::regAddrT     rs2,
    output cpuPkg::regAddrT     rt2,
    input  wire cpuPkg::wordT   rdData1,
    input  wire cpuPkg::wordT   rdData2,
    input  wire cpuPkg::wordT   rdData3,
    input  wire cpuPkg::wordT   rdData4,
    // lane 1 towards execute
    output logic                exValid1,
    output logic                exWrite1,
    output cpuPkg::regAddrT     exDest1,
    output cpuPkg::aluOpT       exAluOp1,
    output cpuPkg::regAddrT     exSrcA1,
    output cpuPkg::regAddrT     exSrcB1,
    output cpuPkg::wordT        exOpA1,
    output cpuPkg::wordT        exOpB1,
    output cpuPkg::wordT        exImm1,
    output logic                exUseImm1,
    // lane 2 towards execute
    output logic                exValid2,
    output logic                exWrite2,
    output cpuPkg::regAddrT     exDest2,
    output cpuPkg::aluOpT       exAluOp2,
    output cpuPkg::regAddrT     exSrcA2,
    output cpuPkg::regAddrT     exSrcB2,
    output cpuPkg::wordT        exOpA2,
    output cpuPkg::wordT        exOpB2,
    output cpuPkg::wordT        exImm2,
    output logic                exUseImm2
);

    logic write1;
    logic write2;
    cpuPkg::regAddrT dest1;
    cpuPkg::regAddrT dest2;
    cpuPkg::aluOpT aluOp1;
    cpuPkg::aluOpT aluOp2;
    cpuPkg::wordT imm1;
    cpuPkg::wordT imm2;
    logic useImm1;
    logic useImm2;

    // one lane's control, anything unknown falls out as a non-writing add
    function automatic void decodeInstr(
        input  cpuPkg::wordT    instr,
        output logic            writes,
        output cpuPkg::regAddrT dest,
        output cpuPkg::aluOpT   aluOp,
        output cpuPkg::wordT    imm,
        output logic            useImm
    );
        cpuPkg::opcodeT opcode;
        cpuPkg::functT funct;
        opcode = instr[31:26];
        funct = instr[5:0];
        writes = 1'b1;
        dest = instr[20:16];
        aluOp = cpuPkg::aluAdd;
        imm = {{16{instr[15]}}, instr[15:0]};
        useImm = 1'b1;
        case (opcode)
            cpuPkg::opRType: begin
                // r-type writes rd and takes both operands from registers
                dest = instr[15:11];
                useImm = 1'b0;
                case (funct)
                    cpuPkg::fnAdd: aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSub: aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:  aluOp = cpuPkg::aluOr;
                    cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
                    default:       writes = 1'b0;
                endcase
            end
            cpuPkg::opAddi: aluOp = cpuPkg::aluAdd;
            // logical immediates are zero extended
            cpuPkg::opAndi: begin
                aluOp = cpuPkg::aluAnd;
                imm = {16'b0, instr[15:0]};
            end
            cpuPkg::opOri: begin
                aluOp = cpuPkg::aluOr;
                imm = {16'b0, instr[15:0]};
            end
            default: writes = 1'b0;
        endcase
    endfunction

    assign rs1 = fdInstr1[25:21];
    assign rt1 = fdInstr1[20:16];
    assign rs2 = fdInstr2[25:21];
    assign rt2 = fdInstr2[20:16];

    always_comb begin
        decodeInstr(fdInstr1, write1, dest1, aluOp1, imm1, useImm1);
        decodeInstr(fdInstr2, write2, dest2, aluOp2, imm2, useImm2);
    end

    // decode/execute register, control bits
    always_ff @(posedge clk) begin
        if (rst) begin
            exValid1 <= 1'b0;
            exValid2 <= 1'b0;
            exWrite1 <= 1'b0;
            exWrite2 <= 1'b0;
        end else if (enable) begin
            exValid1 <= fdValid;
            exValid2 <= fdValid;
            exWrite1 <= write1;
            exWrite2 <= write2;
        end
    end

    // decode/execute register, payload
    always_ff @(posedge clk) begin
        if (enable) begin
            exDest1 <= dest1;
            exAluOp1 <= aluOp1;
            exSrcA1 <= rs1;
            exSrcB1 <= rt1;
            exOpA1 <= rdData1;
            exOpB1 <= rdData2;
            exImm1 <= imm1;
            exUseImm1 <= useImm1;
            exDest2 <= dest2;
            exAluOp2 <= aluOp2;
            exSrcA2 <= rs2;
            exSrcB2 <= rt2;
            exOpA2 <= rdData3;
            exOpB2 <= rdData4;
            exImm2 <= imm2;
            exUseImm2 <= useImm2;
        end
    end

    // no forwarding path exists from lane 1 into lane 2 of the same pair
    pairIndependent: assert property (@(posedge clk) disable iff (rst)
        (fdValid && write1 && dest1 != '0)
            |-> (rs2 != dest1 && (useImm2 || rt2 != dest1)));

endmodule

`default_nettype wire

// ==== source/dualIssueCpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module dualIssueCpu #(
    parameter int imemAddrWidth = 11
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     enable,
    output logic [imemAddrWidth-1:0]      pc,
    input  wire logic                     imemWrEn,
    input  wire logic [imemAddrWidth-1:0] imemWrAddr,
    input  wire cpuPkg::wordT             imemWrData,
    output logic                          wbWrEn1,
    output logic                          wbWrEn2,
    output cpuPkg::regAddrT               wbReg1,
    output cpuPkg::regAddrT               wbReg2,
    output cpuPkg::wordT                  wbData1,
    output cpuPkg::wordT                  wbData2
);

    // fetch to decode
    cpuPkg::wordT fdInstr1;
    cpuPkg::wordT fdInstr2;
    logic fdValid;

    // decode to register file and back
    cpuPkg::regAddrT rs1;
    cpuPkg::regAddrT rt1;
    cpuPkg::regAddrT rs2;
    cpuPkg::regAddrT rt2;
    cpuPkg::wordT rdData1;
    cpuPkg::wordT rdData2;
    cpuPkg::wordT rdData3;
    cpuPkg::wordT rdData4;

    // decode to execute, lane 1
    logic exValid1;
    logic exWrite1;
    cpuPkg::regAddrT exDest1;
    cpuPkg::aluOpT exAluOp1;
    cpuPkg::regAddrT exSrcA1;
    cpuPkg::regAddrT exSrcB1;
    cpuPkg::wordT exOpA1;
    cpuPkg::wordT exOpB1;
    cpuPkg::wordT exImm1;
    logic exUseImm1;

    // decode to execute, lane 2
    logic exValid2;
    logic exWrite2;
    cpuPkg::regAddrT exDest2;
    cpuPkg::aluOpT exAluOp2;
    cpuPkg::regAddrT exSrcA2;
    cpuPkg::regAddrT exSrcB2;
    cpuPkg::wordT exOpA2;
    cpuPkg::wordT exOpB2;
    cpuPkg::wordT exImm2;
    logic exUseImm2;

    // port names line up across the stages
    fetchStage #(
        .imemAddrWidth (imemAddrWidth)
    ) fetch_i (.*);

    decodeStage decode_i (.*);

    registerFile regFile_i (.*);

    // writeback fields feed both the register file and the trace ports
    executeStage execute_i (.*);

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            enable,
    input  wire logic            exValid1,
    input  wire logic            exWrite1,
    input  wire cpuPkg::regAddrT exDest1,
    input  wire cpuPkg::aluOpT   exAluOp1,
    input  wire cpuPkg::regAddrT exSrcA1,
    input  wire cpuPkg::regAddrT exSrcB1,
    input  wire cpuPkg::wordT    exOpA1,
    input  wire cpuPkg::wordT    exOpB1,
    input  wire cpuPkg::wordT    exImm1,
    input  wire logic            exUseImm1,
    input  wire logic            exValid2,
    input  wire logic            exWrite2,
    input  wire cpuPkg::regAddrT exDest2,
    input  wire cpuPkg::aluOpT   exAluOp2,
    input  wire cpuPkg::regAddrT exSrcA2,
    input  wire cpuPkg::regAddrT exSrcB2,
    input  wire cpuPkg::wordT    exOpA2,
    input  wire cpuPkg::wordT    exOpB2,
    input  wire cpuPkg::wordT    exImm2,
    input  wire logic            exUseImm2,
    output logic                 wbWrEn1,
    output logic                 wbWrEn2,
    output cpuPkg::regAddrT      wbReg1,
    output cpuPkg::regAddrT      wbReg2,
    output cpuPkg::wordT         wbData1,
    output cpuPkg::wordT         wbData2
);

    cpuPkg::wordT opA1;
    cpuPkg::wordT opB1;
    cpuPkg::wordT opA2;
    cpuPkg::wordT opB2;
    cpuPkg::wordT result1;
    cpuPkg::wordT result2;
    logic ewWrite1;
    logic ewWrite2;
    cpuPkg::regAddrT ewDest1;
    cpuPkg::regAddrT ewDest2;
    cpuPkg::wordT ewResult1;
    cpuPkg::wordT ewResult2;

    // writeback register bypass, lane 2 is newer so it is checked first
    function automatic cpuPkg::wordT forwardOp(
        input cpuPkg::regAddrT src,
        input cpuPkg::wordT    regVal
    );
        if (src == '0) begin
            return regVal;
        end
        if (ewWrite2 && ewDest2 == src) begin
            return ewResult2;
        end
        if (ewWrite1 && ewDest1 == src) begin
            return ewResult1;
        end
        return regVal;
    endfunction

    always_comb begin
        opA1 = forwardOp(exSrcA1, exOpA1);
        opB1 = exUseImm1 ? exImm1 : forwardOp(exSrcB1, exOpB1);
        opA2 = forwardOp(exSrcA2, exOpA2);
        opB2 = exUseImm2 ? exImm2 : forwardOp(exSrcB2, exOpB2);
    end

    alu laneAlu1 (
        .opA    (opA1),
        .opB    (opB1),
        .aluOp  (exAluOp1),
        .result (result1)
    );

    alu laneAlu2 (
        .opA    (opA2),
        .opB    (opB2),
        .aluOp  (exAluOp2),
        .result (result2)
    );

    // execute/writeback register, r0 destinations are dropped here
    always_ff @(posedge clk) begin
        if (rst) begin
            ewWrite1 <= 1'b0;
            ewWrite2 <= 1'b0;
        end else if (enable) begin
            ewWrite1 <= exValid1 && exWrite1 && exDest1 != '0;
            ewWrite2 <= exValid2 && exWrite2 && exDest2 != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            ewDest1 <= exDest1;
            ewDest2 <= exDest2;
            ewResult1 <= result1;
            ewResult2 <= result2;
        end
    end

    // a frozen pipeline holds writeback, so the write is qualified by enable
    assign wbWrEn1 = ewWrite1 && enable;
    assign wbWrEn2 = ewWrite2 && enable;
    assign wbReg1 = ewDest1;
    assign wbReg2 = ewDest2;
    assign wbData1 = ewResult1;
    assign wbData2 = ewResult2;

endmodule

`default_nettype wire

// ==== source/fetchStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchStage #(
    parameter int imemAddrWidth = 11
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     enable,
    input  wire logic                     imemWrEn,
    input  wire logic [imemAddrWidth-1:0] imemWrAddr,
    input  wire cpuPkg::wordT             imemWrData,
    output logic [imemAddrWidth-1:0]      pc,
    output cpuPkg::wordT                  fdInstr1,
    output cpuPkg::wordT                  fdInstr2,
    output logic                          fdValid
);

    localparam int imemDepth = 2 ** imemAddrWidth;
    localparam logic [imemAddrWidth-1:0] addrOne = 1;

    cpuPkg::wordT imem [imemDepth];
    logic [imemAddrWidth-1:0] pcPlusOne;

    // load port, filled from outside while the pipeline is frozen
    always_ff @(posedge clk) begin
        if (imemWrEn) begin
            imem[imemWrAddr] <= imemWrData;
        end
    end

    // second word of the pair, wraps at the top of memory
    assign pcPlusOne = pc + addrOne;

    // two instructions per enabled cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (enable) begin
            pc <= pcPlusOne + addrOne;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fdValid <= 1'b0;
        end else if (enable) begin
            fdValid <= 1'b1;
        end
    end

    // fetch/decode register, combinational memory read at pc and pc+1
    always_ff @(posedge clk) begin
        if (enable) begin
            fdInstr1 <= imem[pc];
            fdInstr2 <= imem[pcPlusOne];
        end
    end

    // loading while the pipeline runs would race the fetch
    loadWhileFrozen: assert property (@(posedge clk) disable iff (rst)
        imemWrEn |-> !enable);

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire cpuPkg::regAddrT rs1,
    input  wire cpuPkg::regAddrT rt1,
    input  wire cpuPkg::regAddrT rs2,
    input  wire cpuPkg::regAddrT rt2,
    input  wire logic            wbWrEn1,
    input  wire logic            wbWrEn2,
    input  wire cpuPkg::regAddrT wbReg1,
    input  wire cpuPkg::regAddrT wbReg2,
    input  wire cpuPkg::wordT    wbData1,
    input  wire cpuPkg::wordT    wbData2,
    output cpuPkg::wordT         rdData1,
    output cpuPkg::wordT         rdData2,
    output cpuPkg::wordT         rdData3,
    output cpuPkg::wordT         rdData4
);

    cpuPkg::wordT regs [32];

    // same-cycle writes pass through to the readers
    // lane 2 is the younger write and wins
    function automatic cpuPkg::wordT readPort(input cpuPkg::regAddrT addr);
        if (addr == '0) begin
            return '0;
        end
        if (wbWrEn2 && wbReg2 == addr) begin
            return wbData2;
        end
        if (wbWrEn1 && wbReg1 == addr) begin
            return wbData1;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdData1 = readPort(rs1);
        rdData2 = readPort(rt1);
        rdData3 = readPort(rs2);
        rdData4 = readPort(rt2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wbWrEn1) begin
                regs[wbReg1] <= wbData1;
            end
            // the later assignment lets lane 2 override lane 1 on the same index
            if (wbWrEn2) begin
                regs[wbReg2] <= wbData2;
            end
        end
    end

    // register 0 is never a write target
    noZeroWrite: assert property (@(posedge clk) disable iff (rst)
        !(wbWrEn1 && wbReg1 == '0) && !(wbWrEn2 && wbReg2 == '0));

endmodule

`default_nettype wire
